// ==== design/sd_mem_pkg.sv ====
// system RAM geometry
package sd_mem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////
   localparam int word_w     = 32;   // data word
   localparam int addr_w     = 10;   // byte address, 1 KiB
   localparam int bank_n     = 4;    // interleaved banks
   localparam int bank_sel_w = 2;
   localparam int row_n      = 64;   // words per bank
   localparam int row_w      = 6;

   // byte address split: [1:0] offset, [3:2] bank, [9:4] row
   localparam int off_w    = 2;
   localparam int bank_lsb = 2;
   localparam int row_lsb  = 4;

   typedef logic [word_w-1:0]     word_t;
   typedef logic [addr_w-1:0]     addr_t;
   typedef logic [bank_sel_w-1:0] bank_sel_t;
   typedef logic [row_w-1:0]      row_t;

   // one word forward in byte address
   localparam addr_t word_step = addr_t'(4);

endpackage

// ==== design/sd_adma_pkg.sv ====
// adma descriptor and engine definitions
package sd_adma_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // descriptor layout
   ////////////////////////////////////////////////////////////////////////////
   // low word: attr [5:0], length in words [31:16]
   // high word: data or link address
   localparam int attr_valid_bit = 0;
   localparam int attr_end_bit   = 1;
   localparam int act_lsb        = 4;   // action in [5:4]
   localparam int act_w          = 2;
   localparam int len_lsb        = 16;
   localparam int len_w          = 16;

   typedef logic [len_w-1:0] len_t;

   // two words per descriptor
   localparam sd_mem_pkg::addr_t desc_step = sd_mem_pkg::addr_t'(8);

   typedef enum logic [act_w-1:0] {
      act_nop  = 2'b00,  // skip
      act_rsv  = 2'b01,  // reserved, treated as bad
      act_tran = 2'b10,  // move data
      act_link = 2'b11   // jump to another table
   } desc_act_e;

   ////////////////////////////////////////////////////////////////////////////
   // engine
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      st_idle,
      st_fetch_lo,   // read attr/len word
      st_fetch_hi,   // read address word
      st_decode,
      st_xfer,       // one data read per cycle
      st_drain,      // last word returning
      st_next
   } adma_state_e;

   typedef enum logic [1:0] {
      stat_none,
      stat_done,
      stat_error
   } adma_status_e;

endpackage

// ==== design/ram_bank_router.sv ====
// bank request router
module ram_bank_router (
   input  logic                                CLK,
   input  logic                                arst_n,
   input  logic                                host_write,
   input  logic                                host_read,
   input  sd_mem_pkg::addr_t                   host_addr,
   input  sd_mem_pkg::word_t                   host_wdata,
   input  logic                                dma_read,
   input  sd_mem_pkg::addr_t                   dma_addr,
   input  logic                                busy,
   output logic [sd_mem_pkg::bank_n-1:0]       bank_we,
   output logic [sd_mem_pkg::bank_n-1:0]       bank_re,
   output sd_mem_pkg::row_t                    row,
   output sd_mem_pkg::word_t                   wdata,
   output logic                                rd_issue,
   output sd_mem_pkg::bank_sel_t               rd_bank,
   output logic                                rd_is_dma
);

   logic              busy_q;    // engine held the RAM last cycle
   logic              own_dma;
   logic              acc_wr;
   logic              acc_rd;
   logic              aligned;
   sd_mem_pkg::addr_t acc_addr;
   sd_mem_pkg::bank_sel_t sel;

   // ownership stays with the engine through the cycle busy drops
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= 1'b0;
      end else begin
         busy_q <= busy;
      end
   end

   always_comb begin
      own_dma  = busy | busy_q;
      acc_wr   = own_dma ? 1'b0 : host_write;   // engine only reads
      acc_rd   = own_dma ? dma_read : host_read;
      acc_addr = own_dma ? dma_addr : host_addr;
      aligned  = (acc_addr[sd_mem_pkg::off_w-1:0] == '0);
      sel      = acc_addr[sd_mem_pkg::bank_lsb +: sd_mem_pkg::bank_sel_w];
      bank_we  = '0;
      bank_re  = '0;
      if (aligned) begin   // misaligned strobes just vanish
         bank_we[sel] = acc_wr;
         bank_re[sel] = acc_rd;
      end
   end

   assign row   = acc_addr[sd_mem_pkg::row_lsb +: sd_mem_pkg::row_w];
   assign wdata = host_wdata;   // only the host writes

   // read tag for the merge
   assign rd_issue  = acc_rd & aligned;
   assign rd_bank   = sel;
   assign rd_is_dma = own_dma;

endmodule

// ==== design/sys_ram_bank.sv ====
// system RAM bank
module sys_ram_bank (
   input  logic              CLK,
   input  logic              arst_n,
   input  logic              we,
   input  logic              re,
   input  sd_mem_pkg::row_t  row,
   input  sd_mem_pkg::word_t wdata,
   output sd_mem_pkg::word_t rdata
);

   sd_mem_pkg::word_t mem [sd_mem_pkg::row_n];   // one word per row

   ////////////////////////////////////////////////////////////////////////////
   // storage, zero after reset
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < sd_mem_pkg::row_n; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[row] <= wdata;   // lands at the sampling edge
      end
   end

   // registered read port, holds between reads
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         rdata <= '0;
      end else if (re) begin
         rdata <= mem[row];   // old word on same-cycle write
      end
   end

endmodule

// ==== design/ram_read_merge.sv ====
// bank read return merge
module ram_read_merge (
   input  logic                  CLK,
   input  logic                  arst_n,
   input  logic                  rd_issue,
   input  sd_mem_pkg::bank_sel_t rd_bank,
   input  logic                  rd_is_dma,
   input  sd_mem_pkg::word_t     bank_rdata [sd_mem_pkg::bank_n],
   output sd_mem_pkg::word_t     host_rdata,
   output sd_mem_pkg::word_t     dma_rdata,
   output logic                  host_rvalid,
   output logic                  dma_rvalid
);

   logic                  issue_q;
   logic                  is_dma_q;
   sd_mem_pkg::bank_sel_t bank_q;
   sd_mem_pkg::word_t     sel_word;

   // tag lines up with the bank's registered read
   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         issue_q  <= 1'b0;
         is_dma_q <= 1'b0;
         bank_q   <= '0;
      end else begin
         issue_q  <= rd_issue;
         is_dma_q <= rd_is_dma;
         bank_q   <= rd_bank;
      end
   end

   assign sel_word    = bank_rdata[bank_q];
   assign host_rdata  = sel_word;
   assign dma_rdata   = sel_word;
   assign host_rvalid = issue_q & ~is_dma_q;
   assign dma_rvalid  = issue_q & is_dma_q;

endmodule

// ==== design/adma_engine.sv ====
// adma descriptor engine
module adma_engine (
   input  logic              CLK,
   input  logic              arst_n,
   input  logic              start,
   input  sd_mem_pkg::addr_t table_addr,
   output logic              dma_read,
   output sd_mem_pkg::addr_t dma_addr,
   input  sd_mem_pkg::word_t dma_rdata,
   input  logic              dma_rvalid,
   output sd_mem_pkg::word_t card_data,
   output logic              card_valid,
   output logic              busy,
   output logic              done,
   output logic              error
);

   sd_adma_pkg::adma_state_e  state_q, state_d;
   sd_adma_pkg::adma_status_e result_q, result_d;   // one-cycle result
   sd_mem_pkg::addr_t         desc_addr_q, desc_addr_d;
   sd_mem_pkg::addr_t         xfer_addr_q, xfer_addr_d;
   sd_adma_pkg::len_t         remain_q, remain_d;   // reads still to issue
   logic                      end_q, end_d;         // stop after this one
   sd_mem_pkg::word_t         desc_lo_q;            // attr/len word

   // decoded view of the fetched pair
   sd_adma_pkg::desc_act_e act;
   sd_adma_pkg::len_t      len;
   sd_mem_pkg::addr_t      hi_addr;
   logic                   d_valid;
   logic                   d_end;
   logic                   hi_ok;

   always_comb begin
      act     = sd_adma_pkg::desc_act_e'(desc_lo_q[sd_adma_pkg::act_lsb +: sd_adma_pkg::act_w]);
      len     = desc_lo_q[sd_adma_pkg::len_lsb +: sd_adma_pkg::len_w];
      d_valid = desc_lo_q[sd_adma_pkg::attr_valid_bit];
      d_end   = desc_lo_q[sd_adma_pkg::attr_end_bit];
      hi_addr = dma_rdata[sd_mem_pkg::addr_w-1:0];   // high word arrives in decode
      hi_ok   = (hi_addr[sd_mem_pkg::off_w-1:0] == '0);
   end

   ////////////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      state_d     = state_q;
      result_d    = sd_adma_pkg::stat_none;
      desc_addr_d = desc_addr_q;
      xfer_addr_d = xfer_addr_q;
      remain_d    = remain_q;
      end_d       = end_q;
      dma_read    = 1'b0;
      dma_addr    = desc_addr_q;
      case (state_q)
         sd_adma_pkg::st_idle: begin
            if (start) begin
               if (table_addr[sd_mem_pkg::off_w-1:0] != '0) begin
                  result_d = sd_adma_pkg::stat_error;   // bad table base
               end else begin
                  desc_addr_d = table_addr;
                  state_d     = sd_adma_pkg::st_fetch_lo;
               end
            end
         end
         sd_adma_pkg::st_fetch_lo: begin
            dma_read = 1'b1;
            state_d  = sd_adma_pkg::st_fetch_hi;
         end
         sd_adma_pkg::st_fetch_hi: begin
            dma_read = 1'b1;
            dma_addr = desc_addr_q + sd_mem_pkg::word_step;
            state_d  = sd_adma_pkg::st_decode;
         end
         sd_adma_pkg::st_decode: begin
            end_d       = d_end;
            desc_addr_d = desc_addr_q + sd_adma_pkg::desc_step;
            state_d     = sd_adma_pkg::st_next;
            if (!d_valid || act == sd_adma_pkg::act_rsv ||
                ((act == sd_adma_pkg::act_tran || act == sd_adma_pkg::act_link) && !hi_ok)) begin
               result_d = sd_adma_pkg::stat_error;
               state_d  = sd_adma_pkg::st_idle;
            end else begin
               case (act)
                  sd_adma_pkg::act_tran: begin
                     if (len != '0) begin   // empty transfer moves nothing
                        xfer_addr_d = hi_addr;
                        remain_d    = len;
                        state_d     = sd_adma_pkg::st_xfer;
                     end
                  end
                  sd_adma_pkg::act_link: begin
                     desc_addr_d = hi_addr;
                     end_d       = 1'b0;   // end bit means nothing on a link
                  end
                  default: ;   // nop
               endcase
            end
         end
         sd_adma_pkg::st_xfer: begin
            dma_read    = 1'b1;
            dma_addr    = xfer_addr_q;
            xfer_addr_d = xfer_addr_q + sd_mem_pkg::word_step;
            remain_d    = remain_q - sd_adma_pkg::len_t'(1);
            if (remain_q == sd_adma_pkg::len_t'(1)) begin
               state_d = sd_adma_pkg::st_drain;
            end
         end
         sd_adma_pkg::st_drain: state_d = sd_adma_pkg::st_next;   // last word back now
         sd_adma_pkg::st_next: begin
            if (end_q) begin
               result_d = sd_adma_pkg::stat_done;
               state_d  = sd_adma_pkg::st_idle;
            end else begin
               state_d = sd_adma_pkg::st_fetch_lo;
            end
         end
         default: state_d = sd_adma_pkg::st_idle;
      endcase
   end

   always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
         state_q     <= sd_adma_pkg::st_idle;
         result_q    <= sd_adma_pkg::stat_none;
         desc_addr_q <= '0;
         xfer_addr_q <= '0;
         remain_q    <= '0;
         end_q       <= 1'b0;
      end else begin
         state_q     <= state_d;
         result_q    <= result_d;
         desc_addr_q <= desc_addr_d;
         xfer_addr_q <= xfer_addr_d;
         remain_q    <= remain_d;
         end_q       <= end_d;
      end
   end

   // low word returns while the high word is being read
   always_ff @(posedge CLK) begin
      if (state_q == sd_adma_pkg::st_fetch_hi && dma_rvalid) begin
         desc_lo_q <= dma_rdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // outputs
   ////////////////////////////////////////////////////////////////////////////
   assign card_data  = dma_rdata;
   assign card_valid = dma_rvalid &&
                       (state_q == sd_adma_pkg::st_xfer || state_q == sd_adma_pkg::st_drain);
   assign busy       = (state_q != sd_adma_pkg::st_idle);
   assign done       = (result_q == sd_adma_pkg::stat_done);
   assign error      = (result_q == sd_adma_pkg::stat_error);

endmodule

// ==== design/sd_adma_top.sv ====
// sd host adma read path
module sd_adma_top (
   input  logic              CLK,
   input  logic              arst_n,
   input  logic              host_write,
   input  logic              host_read,
   input  sd_mem_pkg::addr_t host_addr,
   input  sd_mem_pkg::word_t host_wdata,
   output sd_mem_pkg::word_t host_rdata,
   output logic              host_rvalid,
   input  logic              start,
   input  sd_mem_pkg::addr_t table_addr,
   output sd_mem_pkg::word_t card_data,
   output logic              card_valid,
   output logic              busy,
   output logic              done,
   output logic              error
);

   // engine side
   logic                  dma_read;
   sd_mem_pkg::addr_t     dma_addr;
   sd_mem_pkg::word_t     dma_rdata;
   logic                  dma_rvalid;

   // bank side
   logic [sd_mem_pkg::bank_n-1:0] bank_we;
   logic [sd_mem_pkg::bank_n-1:0] bank_re;
   sd_mem_pkg::row_t      row;
   sd_mem_pkg::word_t     wdata;
   sd_mem_pkg::word_t     bank_rdata [sd_mem_pkg::bank_n];

   // read tag
   logic                  rd_issue;
   sd_mem_pkg::bank_sel_t rd_bank;
   logic                  rd_is_dma;

   ram_bank_router ram_bank_router_i (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .host_write (host_write),
      .host_read  (host_read),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .dma_read   (dma_read),
      .dma_addr   (dma_addr),
      .busy       (busy),
      .bank_we    (bank_we),
      .bank_re    (bank_re),
      .row        (row),
      .wdata      (wdata),
      .rd_issue   (rd_issue),
      .rd_bank    (rd_bank),
      .rd_is_dma  (rd_is_dma)
   );

   for (genvar b = 0; b < sd_mem_pkg::bank_n; b++) begin : g_bank
      sys_ram_bank sys_ram_bank_i (
         .CLK    (CLK),
         .arst_n (arst_n),
         .we     (bank_we[b]),
         .re     (bank_re[b]),
         .row    (row),
         .wdata  (wdata),
         .rdata  (bank_rdata[b])
      );
   end

   ram_read_merge ram_read_merge_i (
      .CLK         (CLK),
      .arst_n      (arst_n),
      .rd_issue    (rd_issue),
      .rd_bank     (rd_bank),
      .rd_is_dma   (rd_is_dma),
      .bank_rdata  (bank_rdata),
      .host_rdata  (host_rdata),
      .dma_rdata   (dma_rdata),
      .host_rvalid (host_rvalid),
      .dma_rvalid  (dma_rvalid)
   );

   adma_engine adma_engine_i (
      .CLK        (CLK),
      .arst_n     (arst_n),
      .start      (start),
      .table_addr (table_addr),
      .dma_read   (dma_read),
      .dma_addr   (dma_addr),
      .dma_rdata  (dma_rdata),
      .dma_rvalid (dma_rvalid),
      .card_data  (card_data),
      .card_valid (card_valid),
      .busy       (busy),
      .done       (done),
      .error      (error)
   );

endmodule

// ==== tests/sd_adma_tb.sv ====
// sd adma read path testbench
module sd_adma_tb;

   localparam int n_tests     = 6;
   localparam int max_desc    = 3;
   localparam int run_limit   = 600;   // cycles for one descriptor chain
   localparam int host_limit  = 4;
   localparam int busy_limit  = 20;
   localparam int tail_cycles = 4;     // quiet window after the result
   localparam sd_mem_pkg::addr_t poke_addr = 10'h0F0;   // outside every transfer

   logic              CLK = 1'b0;
   logic              arst_n;
   logic              host_write;
   logic              host_read;
   sd_mem_pkg::addr_t host_addr;
   sd_mem_pkg::word_t host_wdata;
   sd_mem_pkg::word_t host_rdata;
   logic              host_rvalid;
   logic              start;
   sd_mem_pkg::addr_t table_addr;
   sd_mem_pkg::word_t card_data;
   logic              card_valid;
   logic              busy;
   logic              done;
   logic              error;

   ////////////////////////////////////////////////////////////////////////////
   // scenario table with one row per test
   ////////////////////////////////////////////////////////////////////////////
   string                     kind_tab     [n_tests];
   sd_mem_pkg::addr_t         tbl_tab      [n_tests];
   sd_adma_pkg::adma_status_e exp_tab      [n_tests];
   bit                        poke_tab     [n_tests];   // host strobes during the run
   int                        desc_cnt_tab [n_tests];
   sd_mem_pkg::addr_t         desc_at_tab  [n_tests][max_desc];
   sd_mem_pkg::word_t         desc_lo_tab  [n_tests][max_desc];
   sd_mem_pkg::word_t         desc_hi_tab  [n_tests][max_desc];

   sd_mem_pkg::word_t mirror [256];   // whole 1 KiB as words
   sd_mem_pkg::word_t exp_words [$];
   sd_mem_pkg::word_t got_words [$];
   int seed         = 32'hdcc7;
   int err_cnt      = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   bit hung         = 1'b0;

   sd_adma_top sd_adma_top_i (
      .CLK         (CLK),
      .arst_n      (arst_n),
      .host_write  (host_write),
      .host_read   (host_read),
      .host_addr   (host_addr),
      .host_wdata  (host_wdata),
      .host_rdata  (host_rdata),
      .host_rvalid (host_rvalid),
      .start       (start),
      .table_addr  (table_addr),
      .card_data   (card_data),
      .card_valid  (card_valid),
      .busy        (busy),
      .done        (done),
      .error       (error)
   );

   always #4 CLK = ~CLK;   // period 8

   function automatic logic [7:0] widx(input sd_mem_pkg::addr_t a);
      return a[9:2];   // word index without the offset bits
   endfunction

   // low descriptor word with len [31:16], act [5:4], end [1] and valid [0]
   function automatic sd_mem_pkg::word_t make_lo(input sd_adma_pkg::desc_act_e act,
                                                 input logic [15:0] len,
                                                 input logic is_end,
                                                 input logic valid);
      return {len, 10'b0, act, 2'b00, is_end, valid};
   endfunction

   task automatic set_row(input int t, input string kind, input sd_mem_pkg::addr_t tbl,
                          input sd_adma_pkg::adma_status_e exp, input bit poke);
      kind_tab[t] = kind;
      tbl_tab[t]  = tbl;
      exp_tab[t]  = exp;
      poke_tab[t] = poke;
   endtask

   task automatic set_desc(input int t, input sd_mem_pkg::addr_t at,
                           input sd_mem_pkg::word_t lo, input sd_mem_pkg::word_t hi);
      desc_at_tab[t][desc_cnt_tab[t]] = at;
      desc_lo_tab[t][desc_cnt_tab[t]] = lo;
      desc_hi_tab[t][desc_cnt_tab[t]] = hi;
      desc_cnt_tab[t]++;
   endtask

   task automatic build_table();
      set_row(0, "host_rw", 10'h000, sd_adma_pkg::stat_none, 1'b0);
      // single transfer with end set
      set_row(1, "chain", 10'h300, sd_adma_pkg::stat_done, 1'b0);
      set_desc(1, 10'h300, make_lo(sd_adma_pkg::act_tran, 16'd5, 1'b1, 1'b1), 32'h010);
      // transfer then link then transfer with end, host pokes while busy
      set_row(2, "chain", 10'h300, sd_adma_pkg::stat_done, 1'b1);
      set_desc(2, 10'h300, make_lo(sd_adma_pkg::act_tran, 16'd4, 1'b0, 1'b1), 32'h020);
      set_desc(2, 10'h308, make_lo(sd_adma_pkg::act_link, 16'd0, 1'b0, 1'b1), 32'h340);
      set_desc(2, 10'h340, make_lo(sd_adma_pkg::act_tran, 16'd6, 1'b1, 1'b1), 32'h080);
      // nop in the middle
      set_row(3, "chain", 10'h300, sd_adma_pkg::stat_done, 1'b0);
      set_desc(3, 10'h300, make_lo(sd_adma_pkg::act_tran, 16'd3, 1'b0, 1'b1), 32'h004);
      set_desc(3, 10'h308, make_lo(sd_adma_pkg::act_nop, 16'd0, 1'b0, 1'b1), 32'h000);
      set_desc(3, 10'h310, make_lo(sd_adma_pkg::act_tran, 16'd4, 1'b1, 1'b1), 32'h0C0);
      // second descriptor has valid clear
      set_row(4, "expect_error", 10'h300, sd_adma_pkg::stat_error, 1'b0);
      set_desc(4, 10'h300, make_lo(sd_adma_pkg::act_tran, 16'd2, 1'b0, 1'b1), 32'h040);
      set_desc(4, 10'h308, make_lo(sd_adma_pkg::act_tran, 16'd3, 1'b1, 1'b0), 32'h050);
      // reserved action
      set_row(5, "expect_error", 10'h300, sd_adma_pkg::stat_error, 1'b0);
      set_desc(5, 10'h300, make_lo(sd_adma_pkg::act_rsv, 16'd2, 1'b1, 1'b1), 32'h060);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // checks and reference model
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_word(input sd_mem_pkg::word_t got, input sd_mem_pkg::word_t exp,
                             input string what);
      if (got !== exp) begin
         $display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_status(input sd_adma_pkg::adma_status_e got,
                               input sd_adma_pkg::adma_status_e exp, input string what);
      if (got !== exp) begin
         $display("FAIL at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
         err_cnt++;
      end
   endtask

   // reference walk of the descriptor chain in the mirror fills exp_words
   task automatic walk_table(input sd_mem_pkg::addr_t base);
      sd_adma_pkg::adma_status_e st;
      sd_mem_pkg::addr_t         a;
      sd_mem_pkg::addr_t         d;
      sd_mem_pkg::word_t         lo;
      sd_mem_pkg::word_t         hi;
      sd_adma_pkg::desc_act_e    act;
      int                        n;
      int                        k;
      exp_words.delete();
      st = sd_adma_pkg::stat_none;
      a  = base;
      n  = 0;
      if (base[1:0] != 2'b00) begin
         st = sd_adma_pkg::stat_error;
      end
      while (st == sd_adma_pkg::stat_none && n < 32) begin
         lo  = mirror[widx(a)];
         hi  = mirror[widx(a + sd_mem_pkg::addr_t'(4))];
         act = sd_adma_pkg::desc_act_e'(lo[5:4]);
         d   = hi[9:0];
         if (!lo[0] || act == sd_adma_pkg::act_rsv) begin
            st = sd_adma_pkg::stat_error;
         end else if ((act == sd_adma_pkg::act_tran || act == sd_adma_pkg::act_link) &&
                      d[1:0] != 2'b00) begin
            st = sd_adma_pkg::stat_error;   // unaligned data or link address
         end else begin
            if (act == sd_adma_pkg::act_tran) begin
               for (k = 0; k < int'(lo[31:16]); k++) begin
                  exp_words.push_back(mirror[widx(d)]);
                  d = d + sd_mem_pkg::addr_t'(4);
               end
            end
            if (act == sd_adma_pkg::act_link) begin
               a = hi[9:0];
            end else begin
               a = a + sd_mem_pkg::addr_t'(8);
               if (lo[1]) begin
                  st = sd_adma_pkg::stat_done;
               end
            end
         end
         n++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // host port and run helpers
   ////////////////////////////////////////////////////////////////////////////
   task automatic step_to_drive();
      @(posedge CLK);
      #1;
   endtask

   task automatic host_write_word(input sd_mem_pkg::addr_t a, input sd_mem_pkg::word_t d);
      step_to_drive();
      host_write = 1'b1;
      host_addr  = a;
      host_wdata = d;
      step_to_drive();
      host_write = 1'b0;
      if (a[1:0] == 2'b00) begin
         mirror[widx(a)] = d;   // RAM drops unaligned writes
      end
   endtask

   task automatic host_read_word(input sd_mem_pkg::addr_t a, output sd_mem_pkg::word_t d);
      int cyc;
      cyc = 0;
      d   = '0;
      step_to_drive();
      host_read = 1'b1;
      host_addr = a;
      step_to_drive();
      host_read = 1'b0;
      @(negedge CLK);
      while (!host_rvalid) begin
         if (cyc == host_limit) begin
            $display("timeout: host read of 0x%03h got no answer", a);
            hung = 1'b1;
            return;
         end
         cyc++;
         @(negedge CLK);
      end
      if (cyc != 0) begin
         $display("host read of 0x%03h answered %0d cycles late", a, cyc);
         err_cnt++;
      end
      d = host_rdata;
   endtask

   // gathers card words until done or error and then watches the idle tail
   task automatic collect_run(output sd_adma_pkg::adma_status_e st);
      int cyc;
      bit saw_done;
      bit saw_err;
      got_words.delete();
      cyc      = 0;
      saw_done = 1'b0;
      saw_err  = 1'b0;
      st       = sd_adma_pkg::stat_none;
      while (!saw_done && !saw_err) begin
         if (cyc == run_limit) begin
            $display("timeout: engine gave neither done nor error in %0d cycles", run_limit);
            hung = 1'b1;
            return;
         end
         @(negedge CLK);
         cyc++;
         if (card_valid) begin
            got_words.push_back(card_data);
         end
         if (host_rvalid) begin
            $display("host read was answered while the engine owned the RAM");
            err_cnt++;
         end
         saw_done = done;
         saw_err  = error;
         if (busy == (saw_done || saw_err)) begin   // busy until the result cycle
            $display("busy was %0b with done %0b and error %0b", busy, done, error);
            err_cnt++;
         end
      end
      if (saw_done && saw_err) begin
         $display("done and error came in the same cycle");
         err_cnt++;
      end
      st = saw_err ? sd_adma_pkg::stat_error : sd_adma_pkg::stat_done;
      for (cyc = 0; cyc < tail_cycles; cyc++) begin
         @(negedge CLK);
         if (card_valid || done || error || busy) begin   // result is a single pulse
            $display("engine was not idle %0d cycles after its result", cyc + 1);
            err_cnt++;
         end
      end
   endtask

   // host write and read while busy must both vanish
   task automatic poke_while_busy();
      int cyc;
      cyc = 0;
      @(negedge CLK);
      while (!busy) begin
         if (cyc == busy_limit) begin
            $display("timeout: engine never went busy");
            hung = 1'b1;
            return;
         end
         cyc++;
         @(negedge CLK);
      end
      step_to_drive();
      host_write = 1'b1;
      host_addr  = poke_addr;
      host_wdata = ~mirror[widx(poke_addr)];
      step_to_drive();
      host_write = 1'b0;
      host_read  = 1'b1;
      step_to_drive();
      host_read  = 1'b0;
   endtask

   task automatic apply_row(input int t);
      sd_mem_pkg::addr_t         a;
      sd_mem_pkg::word_t         r;
      sd_adma_pkg::adma_status_e got_st;
      int                        i;
      for (i = 0; i < 64; i++) begin   // fresh data over all four banks
         host_write_word(sd_mem_pkg::addr_t'(4 * i), sd_mem_pkg::word_t'($random(seed)));
      end
      for (i = 0; i < desc_cnt_tab[t]; i++) begin
         host_write_word(desc_at_tab[t][i], desc_lo_tab[t][i]);
         host_write_word(desc_at_tab[t][i] + sd_mem_pkg::addr_t'(4), desc_hi_tab[t][i]);
      end
      if (kind_tab[t] == "host_rw") begin
         host_write_word(10'h012, sd_mem_pkg::word_t'($random(seed)));   // offset 2
         host_write_word(10'h021, sd_mem_pkg::word_t'($random(seed)));   // offset 1
         for (i = 0; i < 65; i++) begin
            a = (i == 64) ? 10'h200 : sd_mem_pkg::addr_t'(4 * i);   // 0x200 still reset zero
            host_read_word(a, r);
            if (hung) begin
               return;
            end
            check_word(r, mirror[widx(a)], $sformatf("host read 0x%03h", a));
         end
         return;
      end
      walk_table(tbl_tab[t]);
      step_to_drive();
      start      = 1'b1;
      table_addr = tbl_tab[t];
      step_to_drive();
      start      = 1'b0;
      fork
         collect_run(got_st);
         begin
            if (poke_tab[t]) begin
               poke_while_busy();
            end
         end
      join
      if (hung) begin
         return;
      end
      check_status(got_st, exp_tab[t], "run result");
      if (got_words.size() != exp_words.size()) begin
         $display("FAIL at %0t: card got %0d words, expected %0d",
                  $time, got_words.size(), exp_words.size());
         err_cnt++;
      end
      for (i = 0; i < got_words.size() && i < exp_words.size(); i++) begin
         check_word(got_words[i], exp_words[i], $sformatf("card word %0d", i));
      end
      if (poke_tab[t]) begin
         host_read_word(poke_addr, r);
         if (hung) begin
            return;
         end
         check_word(r, mirror[widx(poke_addr)], "word after host write while busy");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      int errs_before;
      arst_n     = 1'b0;
      host_write = 1'b0;
      host_read  = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      start      = 1'b0;
      table_addr = '0;
      for (int i = 0; i < 256; i++) begin
         mirror[i] = '0;   // RAM clears on reset
      end
      build_table();
      repeat (5) @(posedge CLK);
      #1;
      arst_n = 1'b1;
      for (int t = 0; t < n_tests && !hung; t++) begin
         errs_before = err_cnt;
         apply_row(t);
         if (hung || err_cnt != errs_before) begin
            $display("test %0d %s: failed", t, kind_tab[t]);
            tests_failed++;
         end else begin
            $display("test %0d %s: passed", t, kind_tab[t]);
            tests_passed++;
         end
      end
      $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
               tests_passed + tests_failed, tests_passed, tests_failed, err_cnt);
      if (tests_failed == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== build.f ====
design/sd_mem_pkg.sv
design/sd_adma_pkg.sv
design/ram_bank_router.sv
design/sys_ram_bank.sv
design/ram_read_merge.sv
design/adma_engine.sv
design/sd_adma_top.sv
tests/sd_adma_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the sd adma testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   -f build.f \
   --top-module sd_adma_tb \
   -o sd_adma_sim

sim_out=$(./obj_dir/sd_adma_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Verification passed"; then
   exit 0
else
   exit 1
fi
